/* hw/floo_pkg.sv */
// ====================
// Routing package for the mesh router node
// Coordinates and port direction names
// ====================

package floo_pkg;

  // Number of router ports, fixed by XY routing on a 2D mesh
  localparam int unsigned NumDirs = 5;

  // Node coordinate in the mesh
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } coord_t;

  // Port index, also used as the output direction of a flit
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

endpackage

/* hw/floo_flit_pkg.sv */
// ====================
// Flit formats of the three networks
// Every flit carries the same header in its hdr field
// ====================

package floo_flit_pkg;

  import floo_pkg::*;

  // Common header with destination and source node
  typedef struct packed {
    coord_t dst_id;
    coord_t src_id;
  } hdr_t;

  // Narrow request network
  typedef struct packed {
    hdr_t        hdr;
    logic [31:0] payload;
  } floo_req_flit_t;

  // Response network
  typedef struct packed {
    hdr_t       hdr;
    logic [1:0] resp;
    logic [7:0] tag;
  } floo_rsp_flit_t;

  // Wide data network
  typedef struct packed {
    hdr_t         hdr;
    logic [127:0] data;
  } floo_wide_flit_t;

endpackage

/* hw/floo_fifo.sv */
// ====================
// Input buffer of one router port
// Circular buffer, no fall-through
// ====================

`timescale 1ns/10ps

module floo_fifo #(
  parameter type         flit_t = logic,
  parameter int unsigned Depth  = 2
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  push_i,
  input  flit_t data_i,
  output logic  full_o,
  input  logic  pop_i,
  output logic  empty_o,
  output flit_t head_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  flit_t           mem [Depth];
  logic [PtrW-1:0] rd_ptr;
  logic [PtrW-1:0] wr_ptr;
  logic [CntW-1:0] count;
  logic            do_push;
  logic            do_pop;

  // Wraps a pointer at the buffer depth
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count == CntW'(Depth));
  assign empty_o = (count == '0);
  assign head_o  = mem[rd_ptr];

  // Pop on an empty buffer is dropped
  assign do_pop  = pop_i && !empty_o;
  // When full, a push only goes in if the head leaves in the same cycle
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

/* hw/floo_route_ctrl.sv */
// ====================
// Route and arbitration control
// XY routing of each head flit and one round-robin arbiter per output
// ====================

`timescale 1ns/10ps

module floo_route_ctrl
  import floo_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  coord_t                            id_i,
  input  logic   [NumDirs-1:0]              head_valid_i,
  input  coord_t [NumDirs-1:0]              head_dst_i,
  input  logic   [NumDirs-1:0]              out_free_i,
  output logic   [NumDirs-1:0]              pop_o,
  output logic   [NumDirs-1:0][NumDirs-1:0] sel_o,
  output logic   [NumDirs-1:0]              out_load_o
);

  route_dir_e [NumDirs-1:0]              route_dir;
  // Requests indexed as [output][input]
  logic       [NumDirs-1:0][NumDirs-1:0] req;
  logic       [NumDirs-1:0][2:0]         rr_ptr;
  logic       [NumDirs-1:0][2:0]         rr_next;

  // Dimension order: x first, then y
  always_comb begin
    for (int i = 0; i < NumDirs; i++) begin
      if (head_dst_i[i].x > id_i.x) begin
        route_dir[i] = East;
      end else if (head_dst_i[i].x < id_i.x) begin
        route_dir[i] = West;
      end else if (head_dst_i[i].y > id_i.y) begin
        route_dir[i] = North;
      end else if (head_dst_i[i].y < id_i.y) begin
        route_dir[i] = South;
      end else begin
        route_dir[i] = Local;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NumDirs; o++) begin
      for (int i = 0; i < NumDirs; i++) begin
        req[o][i] = head_valid_i[i] && (int'(route_dir[i]) == o);
      end
    end
  end

  // Search starts at the pointer and wraps around the five inputs
  always_comb begin
    int unsigned idx;
    logic        found;
    sel_o   = '0;
    rr_next = rr_ptr;
    for (int unsigned o = 0; o < NumDirs; o++) begin
      found = 1'b0;
      for (int unsigned k = 0; k < NumDirs; k++) begin
        idx = rr_ptr[o] + k;
        if (idx >= NumDirs) begin
          idx = idx - NumDirs;
        end
        // No grant while the output register cannot take a flit
        if (!found && out_free_i[o] && req[o][idx]) begin
          found        = 1'b1;
          sel_o[o][idx] = 1'b1;
          rr_next[o]   = (idx == NumDirs - 1) ? 3'd0 : 3'(idx + 1);
        end
      end
    end
  end

  // An input routes to one output only, so it sees at most one grant
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < NumDirs; o++) begin
      pop_o         = pop_o | sel_o[o];
      out_load_o[o] = |sel_o[o];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // All pointers start at Local
      rr_ptr <= '0;
    end else begin
      rr_ptr <= rr_next;
    end
  end

endmodule

/* hw/floo_out_stage.sv */
// ====================
// Output stage of one router port
// One-hot crossbar mux into a registered valid/ready output
// ====================

`timescale 1ns/10ps

module floo_out_stage
  import floo_pkg::*;
#(
  parameter type flit_t = logic
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic  [NumDirs-1:0]   sel_i,
  input  logic                  load_i,
  input  flit_t [NumDirs-1:0]   cand_i,
  output logic                  free_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output flit_t                 data_o
);

  flit_t mux_flit;
  logic  valid_q;
  flit_t data_q;

  // Select is one-hot, at most one candidate matches
  always_comb begin
    mux_flit = '0;
    for (int i = 0; i < NumDirs; i++) begin
      if (sel_i[i]) begin
        mux_flit = cand_i[i];
      end
    end
  end

  // Register can take a new flit when empty or drained this cycle
  assign free_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Flit is held under back-pressure
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_q <= mux_flit;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* hw/floo_router.sv */
// ====================
// Five-port XY router for one flit type
// Input FIFOs, route control and registered outputs
// ====================

`timescale 1ns/10ps

module floo_router
  import floo_pkg::*;
#(
  parameter type         flit_t      = logic,
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  coord_t                id_i,
  input  logic  [NumDirs-1:0]   valid_i,
  output logic  [NumDirs-1:0]   ready_o,
  input  flit_t [NumDirs-1:0]   data_i,
  output logic  [NumDirs-1:0]   valid_o,
  input  logic  [NumDirs-1:0]   ready_i,
  output flit_t [NumDirs-1:0]   data_o
);

  logic   [NumDirs-1:0]              in_full;
  logic   [NumDirs-1:0]              in_empty;
  logic   [NumDirs-1:0]              head_valid;
  flit_t  [NumDirs-1:0]              head_flit;
  coord_t [NumDirs-1:0]              head_dst;
  logic   [NumDirs-1:0]              pop;
  logic   [NumDirs-1:0][NumDirs-1:0] sel;
  logic   [NumDirs-1:0]              out_load;
  logic   [NumDirs-1:0]              out_free;

  for (genvar i = 0; i < NumDirs; i++) begin : gen_in_port
    assign ready_o[i]    = !in_full[i];
    assign head_valid[i] = !in_empty[i];
    assign head_dst[i]   = head_flit[i].hdr.dst_id;

    floo_fifo #(
      .flit_t ( flit_t      ),
      .Depth  ( InFifoDepth )
    ) i_in_fifo (
      .clk_i,
      .rst_i,
      .push_i  ( valid_i[i] && !in_full[i] ),
      .data_i  ( data_i[i]                 ),
      .full_o  ( in_full[i]                ),
      .pop_i   ( pop[i]                    ),
      .empty_o ( in_empty[i]               ),
      .head_o  ( head_flit[i]              )
    );
  end

  floo_route_ctrl i_route_ctrl (
    .clk_i,
    .rst_i,
    .id_i,
    .head_valid_i ( head_valid ),
    .head_dst_i   ( head_dst   ),
    .out_free_i   ( out_free   ),
    .pop_o        ( pop        ),
    .sel_o        ( sel        ),
    .out_load_o   ( out_load   )
  );

  for (genvar o = 0; o < NumDirs; o++) begin : gen_out_port
    floo_out_stage #(
      .flit_t ( flit_t )
    ) i_out_stage (
      .clk_i,
      .rst_i,
      .sel_i   ( sel[o]      ),
      .load_i  ( out_load[o] ),
      .cand_i  ( head_flit   ),
      .free_o  ( out_free[o] ),
      .valid_o ( valid_o[o]  ),
      .ready_i ( ready_i[o]  ),
      .data_o  ( data_o[o]   )
    );
  end

endmodule

/* hw/floo_nw_router.sv */
// ====================
// Router node with request, response and wide networks
// One generic router per network, all at the same coordinate
// ====================

`timescale 1ns/10ps

module floo_nw_router
  import floo_pkg::*;
  import floo_flit_pkg::*;
#(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  coord_t                          id_i,
  // Narrow request network
  input  logic            [NumDirs-1:0]   req_valid_i,
  output logic            [NumDirs-1:0]   req_ready_o,
  input  floo_req_flit_t  [NumDirs-1:0]   req_data_i,
  output logic            [NumDirs-1:0]   req_valid_o,
  input  logic            [NumDirs-1:0]   req_ready_i,
  output floo_req_flit_t  [NumDirs-1:0]   req_data_o,
  // Response network
  input  logic            [NumDirs-1:0]   rsp_valid_i,
  output logic            [NumDirs-1:0]   rsp_ready_o,
  input  floo_rsp_flit_t  [NumDirs-1:0]   rsp_data_i,
  output logic            [NumDirs-1:0]   rsp_valid_o,
  input  logic            [NumDirs-1:0]   rsp_ready_i,
  output floo_rsp_flit_t  [NumDirs-1:0]   rsp_data_o,
  // Wide data network
  input  logic            [NumDirs-1:0]   wide_valid_i,
  output logic            [NumDirs-1:0]   wide_ready_o,
  input  floo_wide_flit_t [NumDirs-1:0]   wide_data_i,
  output logic            [NumDirs-1:0]   wide_valid_o,
  input  logic            [NumDirs-1:0]   wide_ready_i,
  output floo_wide_flit_t [NumDirs-1:0]   wide_data_o
);

  floo_router #(
    .flit_t      ( floo_req_flit_t ),
    .InFifoDepth ( InFifoDepth     )
  ) i_req_router (
    .clk_i,
    .rst_i,
    .id_i,
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_data_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .data_o  ( req_data_o  )
  );

  floo_router #(
    .flit_t      ( floo_rsp_flit_t ),
    .InFifoDepth ( InFifoDepth     )
  ) i_rsp_router (
    .clk_i,
    .rst_i,
    .id_i,
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .data_i  ( rsp_data_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_data_o  )
  );

  floo_router #(
    .flit_t      ( floo_wide_flit_t ),
    .InFifoDepth ( InFifoDepth      )
  ) i_wide_router (
    .clk_i,
    .rst_i,
    .id_i,
    .valid_i ( wide_valid_i ),
    .ready_o ( wide_ready_o ),
    .data_i  ( wide_data_i  ),
    .valid_o ( wide_valid_o ),
    .ready_i ( wide_ready_i ),
    .data_o  ( wide_data_o  )
  );

endmodule

/* tb/floo_router_asserts.sv */
// ====================
// Handshake and reset checks of one router
// Bound into every floo_router instance
// ====================

`timescale 1ns/10ps

module floo_router_asserts
  import floo_pkg::*;
#(
  parameter type flit_t = logic
) (
  input logic                clk_i,
  input logic                rst_i,
  input logic  [NumDirs-1:0] valid_o,
  input logic  [NumDirs-1:0] ready_i,
  input flit_t [NumDirs-1:0] data_o,
  input logic  [NumDirs-1:0] out_load_i
);

  // Outputs come out of reset empty
  assert property (@(posedge clk_i) $past(rst_i) |-> (valid_o == '0))
    else $error("valid_o is high right after reset");

  for (genvar o = 0; o < NumDirs; o++) begin : gen_port_chk
    assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o[o] && !ready_i[o]) |=> valid_o[o])
      else $error("valid_o[%0d] dropped without a transfer", o);

    assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o[o] && !ready_i[o]) |=> $stable(data_o[o]))
      else $error("data_o[%0d] changed while waiting for ready", o);

    // A grant never overwrites a flit that still waits in the output register
    assert property (@(posedge clk_i) disable iff (rst_i)
      out_load_i[o] |-> (!valid_o[o] || ready_i[o]))
      else $error("Output %0d loaded while its flit was still waiting", o);
  end

endmodule

bind floo_router floo_router_asserts #(
  .flit_t ( flit_t )
) i_router_asserts (
  .clk_i      ( clk_i    ),
  .rst_i      ( rst_i    ),
  .valid_o    ( valid_o  ),
  .ready_i    ( ready_i  ),
  .data_o     ( data_o   ),
  .out_load_i ( out_load )
);

/* tb/tb_floo_nw_router.sv */
// ====================
// Testbench of the three-network router node
// Random traffic checked against a queue model
// ====================

`timescale 1ns/10ps

module tb_floo_nw_router
  import floo_pkg::*;
  import floo_flit_pkg::*;
;

  localparam int NumRandCycles = 3000;
  localparam int NumFairCycles = 200;
  localparam int TotalCycles   = NumRandCycles + NumFairCycles + 1000;
  localparam int ModeIdle      = 0;
  localparam int ModeRand      = 1;
  localparam int ModeFair      = 2;
  localparam logic [3:0] NodeId = 4'b01_10;

  logic         clk;
  logic         rst;
  logic  [31:0] lfsr;
  logic         fair_on;
  // Flat views of the three networks with flits right-aligned in 136 bits
  logic [4:0]   in_valid [3];
  logic [4:0]   in_ready [3];
  logic [135:0] in_data  [3][5];
  logic [4:0]   out_valid [3];
  logic [4:0]   out_ready [3];
  logic [135:0] out_data  [3][5];
  logic         held      [3][5];
  logic [135:0] held_data [3][5];
  int           gap [5];
  // One queue of expected flits per network, output and input
  logic [135:0] exp_q [75][$];

  logic            [NumDirs-1:0] req_ready_o, rsp_ready_o, wide_ready_o;
  logic            [NumDirs-1:0] req_valid_o, rsp_valid_o, wide_valid_o;
  floo_req_flit_t  [NumDirs-1:0] req_data_i, req_data_o;
  floo_rsp_flit_t  [NumDirs-1:0] rsp_data_i, rsp_data_o;
  floo_wide_flit_t [NumDirs-1:0] wide_data_i, wide_data_o;

  for (genvar i = 0; i < NumDirs; i++) begin : gen_map
    assign req_data_i[i]  = in_data[0][i][39:0];
    assign rsp_data_i[i]  = in_data[1][i][17:0];
    assign wide_data_i[i] = in_data[2][i];
    assign out_data[0][i] = {96'b0, req_data_o[i]};
    assign out_data[1][i] = {118'b0, rsp_data_o[i]};
    assign out_data[2][i] = wide_data_o[i];
  end
  assign in_ready[0]  = req_ready_o;
  assign in_ready[1]  = rsp_ready_o;
  assign in_ready[2]  = wide_ready_o;
  assign out_valid[0] = req_valid_o;
  assign out_valid[1] = rsp_valid_o;
  assign out_valid[2] = wide_valid_o;

  floo_nw_router #(
    .InFifoDepth ( 2 )
  ) floo_nw_router_inst (
    .clk_i        ( clk          ),
    .rst_i        ( rst          ),
    .id_i         ( NodeId       ),
    .req_valid_i  ( in_valid[0]  ),
    .req_ready_o  ( req_ready_o  ),
    .req_data_i   ( req_data_i   ),
    .req_valid_o  ( req_valid_o  ),
    .req_ready_i  ( out_ready[0] ),
    .req_data_o   ( req_data_o   ),
    .rsp_valid_i  ( in_valid[1]  ),
    .rsp_ready_o  ( rsp_ready_o  ),
    .rsp_data_i   ( rsp_data_i   ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_ready_i  ( out_ready[1] ),
    .rsp_data_o   ( rsp_data_o   ),
    .wide_valid_i ( in_valid[2]  ),
    .wide_ready_o ( wide_ready_o ),
    .wide_data_i  ( wide_data_i  ),
    .wide_valid_o ( wide_valid_o ),
    .wide_ready_i ( out_ready[2] ),
    .wide_data_o  ( wide_data_o  )
  );

  always #2 clk = ~clk;

  function automatic int net_width(input int n);
    return (n == 0) ? 40 : (n == 1) ? 18 : 136;
  endfunction

  function automatic string net_name(input int n);
    return (n == 0) ? "req" : (n == 1) ? "rsp" : "wide";
  endfunction

  // Header sits in the top byte with dst above src
  function automatic logic [3:0] dst_of(input int n, input logic [135:0] f);
    return f[net_width(n)-1 -: 4];
  endfunction

  function automatic int src_of(input int n, input logic [135:0] f);
    return int'(f[net_width(n)-5 -: 4]);
  endfunction

  function automatic logic [135:0] make_flit(input int n, input logic [3:0] dst,
                                             input logic [3:0] src, input logic [127:0] p);
    return (136'({dst, src}) << (net_width(n) - 8)) | {8'b0, p};
  endfunction

  // X first and then y
  function automatic int xy_dir(input logic [3:0] dst);
    if (dst[3:2] > NodeId[3:2]) return int'(East);
    if (dst[3:2] < NodeId[3:2]) return int'(West);
    if (dst[1:0] > NodeId[1:0]) return int'(North);
    if (dst[1:0] < NodeId[1:0]) return int'(South);
    return int'(Local);
  endfunction

  task automatic draw(input int nbits, output logic [127:0] v);
    logic b;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], b};
      v    = {v[126:0], b};
    end
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Stopping at the first error");
  endtask

  function automatic logic busy();
    logic b;
    b = 1'b0;
    for (int k = 0; k < 75; k++) begin
      if (exp_q[k].size() != 0) b = 1'b1;
    end
    for (int n = 0; n < 3; n++) begin
      if (in_valid[n] != '0 || out_valid[n] != '0) b = 1'b1;
    end
    return b;
  endfunction

  // Called right after a rising edge, so handshake values are pre-edge
  task automatic drive_inputs(input int mode);
    logic [127:0] r;
    logic [3:0]   dst;
    for (int n = 0; n < 3; n++) begin
      for (int i = 0; i < NumDirs; i++) begin
        // A pending flit stays until it is taken
        if (!(in_valid[n][i] && !in_ready[n][i])) begin
          dst = NodeId;
          if (mode == ModeRand) begin
            draw(1, r);
            in_valid[n][i] <= r[0];
            draw(4, r);
            dst = r[3:0];
          end else begin
            in_valid[n][i] <= (mode == ModeFair) && (n == 0);
          end
          draw(net_width(n) - 8, r);
          in_data[n][i] <= make_flit(n, dst, 4'(i), r);
        end
      end
      for (int o = 0; o < NumDirs; o++) begin
        if (mode == ModeRand) begin
          draw(1, r);
          out_ready[n][o] <= r[0];
        end else begin
          out_ready[n][o] <= 1'b1;
        end
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (busy() && waited < 200) begin
      @(posedge clk);
      drive_inputs(ModeIdle);
      #1;
      waited++;
    end
    assert (!busy()) else fail_now("Traffic did not drain, flits are still expected");
  endtask

  // Scoreboard that records accepted flits and matches delivered ones
  always @(posedge clk) begin : monitor
    logic [135:0] exp_flit;
    int           s;
    int           key;
    if (!rst) begin
      for (int n = 0; n < 3; n++) begin
        for (int i = 0; i < NumDirs; i++) begin
          if (in_valid[n][i] && in_ready[n][i]) begin
            exp_q[n*25 + xy_dir(dst_of(n, in_data[n][i]))*5 + i].push_back(in_data[n][i]);
          end
        end
        for (int o = 0; o < NumDirs; o++) begin
          if (held[n][o]) begin
            assert (out_valid[n][o]) else fail_now($sformatf(
              "%s_valid_o[%0d] dropped before its transfer at %0t", net_name(n), o, $time));
            assert (out_data[n][o] == held_data[n][o]) else fail_now($sformatf(
              "Mismatch at %0t: %s_data_o[%0d] = %h, expected %h", $time, net_name(n), o,
              out_data[n][o], held_data[n][o]));
          end
          if (out_valid[n][o] && out_ready[n][o]) begin
            s   = src_of(n, out_data[n][o]);
            key = n*25 + o*5 + s;
            assert (s < NumDirs && exp_q[key].size() > 0) else fail_now($sformatf(
              "Flit %h at %s_data_o[%0d] was never sent to that port (time %0t)",
              out_data[n][o], net_name(n), o, $time));
            exp_flit = exp_q[key].pop_front();
            assert (out_data[n][o] == exp_flit) else fail_now($sformatf(
              "Mismatch at %0t: %s_data_o[%0d] = %h, expected %h", $time, net_name(n), o,
              out_data[n][o], exp_flit));
            if (fair_on && n == 0 && o == int'(Local)) begin
              for (int k = 0; k < NumDirs; k++) begin
                gap[k] = (k == s) ? 0 : gap[k] + 1;
                assert (gap[k] <= 4) else fail_now($sformatf(
                  "Input %0d waited more than 4 grants of req output Local", k));
              end
            end
          end
          held[n][o]      = out_valid[n][o] && !out_ready[n][o];
          held_data[n][o] = out_data[n][o];
        end
      end
    end
  end

  initial begin : watchdog
    #(TotalCycles * 4 * 4);
    fail_now("Timeout, the run did not finish in time");
  end

  initial begin : stimulus
    logic [135:0] flit;
    clk     = 1'b0;
    rst     = 1'b1;
    lfsr    = 32'h19b3;
    fair_on = 1'b0;
    for (int n = 0; n < 3; n++) begin
      in_valid[n]  = '0;
      out_ready[n] = '1;
      for (int i = 0; i < NumDirs; i++) begin
        in_data[n][i] = '0;
        held[n][i]    = 1'b0;
      end
    end
    for (int k = 0; k < NumDirs; k++) gap[k] = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    #1;
    for (int n = 0; n < 3; n++) begin
      assert (out_valid[n] == '0 && in_ready[n] == '1) else fail_now($sformatf(
        "After reset %s valid_o is %b and ready_o is %b", net_name(n), out_valid[n],
        in_ready[n]));
    end

    // Single flit from Local to East takes two cycles
    flit = make_flit(0, 4'b11_10, 4'd0, 128'h1234_5678);
    @(posedge clk);
    in_valid[0][0] <= 1'b1;
    in_data[0][0]  <= flit;
    @(posedge clk);
    in_valid[0][0] <= 1'b0;
    #1;
    assert (out_valid[0] == '0) else fail_now("req flit left one cycle too early");
    @(posedge clk);
    #1;
    assert (out_valid[0][int'(East)]) else fail_now("req flit not at East after 2 cycles");
    assert (out_data[0][int'(East)] == flit) else fail_now($sformatf(
      "Mismatch at %0t: req_data_o[2] = %h, expected %h", $time,
      out_data[0][int'(East)], flit));
    drain();

    repeat (NumRandCycles) begin
      @(posedge clk);
      drive_inputs(ModeRand);
    end
    drain();

    // All req inputs aim at Local
    fair_on = 1'b1;
    repeat (NumFairCycles) begin
      @(posedge clk);
      drive_inputs(ModeFair);
    end
    #1;
    fair_on = 1'b0;
    drain();

    $display("** PASS **");
    $finish;
  end

endmodule

/* sim.f */
hw/floo_pkg.sv
hw/floo_flit_pkg.sv
hw/floo_fifo.sv
hw/floo_route_ctrl.sv
hw/floo_out_stage.sv
hw/floo_router.sv
hw/floo_nw_router.sv
tb/floo_router_asserts.sv
tb/tb_floo_nw_router.sv

/* run.sh */
#!/bin/sh
# Build and run the router node testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_floo_nw_router -f sim.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q '\*\* PASS \*\*' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
